//--- Makefile
# Verilator build and run for the PPU video path

VERILATOR ?= verilator
TOP       ?= tb_ppu_video
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP OBJ_DIR FILELIST VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
source/video_timing_pkg.sv
source/nes_color_pkg.sv
source/nes_palette.sv
source/scanline_buffer.sv
source/vga.sv
source/ppu_video.sv
testbench/tb_ppu_video.sv

//--- source/nes_color_pkg.sv
package nes_color_pkg;

    // index into the 64-entry system palette
    typedef logic [5:0] pal_idx_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // one pixel from the renderer
    typedef struct packed {
        logic [7:0] x;    // column within the line
        pal_idx_t   idx;
    } pix_wr_t;

endpackage

//--- source/nes_palette.sv
`timescale 1ns/1ps

module nes_palette (
    input  nes_color_pkg::pal_idx_t idx,
    output nes_color_pkg::rgb_t     color
);
    import nes_color_pkg::*;

    always_comb begin
        case (idx)
            6'h00: color = rgb_t'{8'd84,  8'd84,  8'd84};
            6'h01: color = rgb_t'{8'd0,   8'd30,  8'd116};
            6'h02: color = rgb_t'{8'd8,   8'd16,  8'd144};
            6'h03: color = rgb_t'{8'd48,  8'd0,   8'd136};
            6'h04: color = rgb_t'{8'd68,  8'd0,   8'd100};
            6'h05: color = rgb_t'{8'd92,  8'd0,   8'd48};
            6'h06: color = rgb_t'{8'd84,  8'd4,   8'd0};
            6'h07: color = rgb_t'{8'd60,  8'd24,  8'd0};
            6'h08: color = rgb_t'{8'd32,  8'd42,  8'd0};
            6'h09: color = rgb_t'{8'd8,   8'd58,  8'd0};
            6'h0a: color = rgb_t'{8'd0,   8'd64,  8'd0};
            6'h0b: color = rgb_t'{8'd0,   8'd60,  8'd0};
            6'h0c: color = rgb_t'{8'd0,   8'd50,  8'd60};
            6'h0d: color = rgb_t'{8'd0,   8'd0,   8'd0};
            6'h0e: color = rgb_t'{8'd0,   8'd0,   8'd0};
            6'h0f: color = rgb_t'{8'd0,   8'd0,   8'd0};
            // second row, brighter
            6'h10: color = rgb_t'{8'd152, 8'd150, 8'd152};
            6'h11: color = rgb_t'{8'd8,   8'd76,  8'd196};
            6'h12: color = rgb_t'{8'd48,  8'd50,  8'd236};
            6'h13: color = rgb_t'{8'd92,  8'd30,  8'd228};
            6'h14: color = rgb_t'{8'd136, 8'd20,  8'd176};
            6'h15: color = rgb_t'{8'd160, 8'd20,  8'd100};
            6'h16: color = rgb_t'{8'd152, 8'd34,  8'd32};
            6'h17: color = rgb_t'{8'd120, 8'd60,  8'd0};
            6'h18: color = rgb_t'{8'd84,  8'd90,  8'd0};
            6'h19: color = rgb_t'{8'd40,  8'd114, 8'd0};
            6'h1a: color = rgb_t'{8'd8,   8'd124, 8'd0};
            6'h1b: color = rgb_t'{8'd0,   8'd118, 8'd40};
            6'h1c: color = rgb_t'{8'd0,   8'd102, 8'd120};
            6'h1d: color = rgb_t'{8'd0,   8'd0,   8'd0};
            6'h1e: color = rgb_t'{8'd0,   8'd0,   8'd0};
            6'h1f: color = rgb_t'{8'd0,   8'd0,   8'd0};
            6'h20: color = rgb_t'{8'd236, 8'd238, 8'd236};
            6'h21: color = rgb_t'{8'd76,  8'd154, 8'd236};
            6'h22: color = rgb_t'{8'd120, 8'd124, 8'd236};
            6'h23: color = rgb_t'{8'd176, 8'd98,  8'd236};
            6'h24: color = rgb_t'{8'd228, 8'd84,  8'd236};
            6'h25: color = rgb_t'{8'd236, 8'd88,  8'd180};
            6'h26: color = rgb_t'{8'd236, 8'd106, 8'd100};
            6'h27: color = rgb_t'{8'd212, 8'd136, 8'd32};
            6'h28: color = rgb_t'{8'd160, 8'd170, 8'd0};
            6'h29: color = rgb_t'{8'd116, 8'd196, 8'd0};
            6'h2a: color = rgb_t'{8'd76,  8'd208, 8'd32};
            6'h2b: color = rgb_t'{8'd56,  8'd204, 8'd108};
            6'h2c: color = rgb_t'{8'd56,  8'd180, 8'd204};
            6'h2d: color = rgb_t'{8'd60,  8'd60,  8'd60};
            6'h2e: color = rgb_t'{8'd0,   8'd0,   8'd0};
            6'h2f: color = rgb_t'{8'd0,   8'd0,   8'd0};
            // pastel row
            6'h30: color = rgb_t'{8'd236, 8'd238, 8'd236};
            6'h31: color = rgb_t'{8'd168, 8'd204, 8'd236};
            6'h32: color = rgb_t'{8'd188, 8'd188, 8'd236};
            6'h33: color = rgb_t'{8'd212, 8'd178, 8'd236};
            6'h34: color = rgb_t'{8'd236, 8'd174, 8'd236};
            6'h35: color = rgb_t'{8'd236, 8'd174, 8'd212};
            6'h36: color = rgb_t'{8'd236, 8'd180, 8'd176};
            6'h37: color = rgb_t'{8'd228, 8'd196, 8'd144};
            6'h38: color = rgb_t'{8'd204, 8'd210, 8'd120};
            6'h39: color = rgb_t'{8'd180, 8'd222, 8'd120};
            6'h3a: color = rgb_t'{8'd168, 8'd226, 8'd144};
            6'h3b: color = rgb_t'{8'd152, 8'd226, 8'd180};
            6'h3c: color = rgb_t'{8'd160, 8'd214, 8'd228};
            6'h3d: color = rgb_t'{8'd160, 8'd162, 8'd160};
            6'h3e: color = rgb_t'{8'd0,   8'd0,   8'd0};
            6'h3f: color = rgb_t'{8'd0,   8'd0,   8'd0};
        endcase
    end

endmodule

//--- source/ppu_video.sv
`timescale 1ns/1ps

module ppu_video #(
    parameter int line_px = 256
) (
    input                           clk,
    input                           clk_en,
    input                           rst_n,
    input                           retro_look,
    input  nes_color_pkg::pix_wr_t  pix_wr,
    input                           pix_wr_valid,
    input                           line_done,
    output logic                    hsync_n,
    output logic                    vsync_n,
    output logic                    blank,
    output nes_color_pkg::rgb_t     pixel
);
    import nes_color_pkg::*;

    logic [7:0] buf_idx;
    pal_idx_t   buf_pix;

    // buffer runs every cycle, only the VGA side follows clk_en
    scanline_buffer #(
        .line_px (line_px)
    ) u_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (pix_wr),
        .wr_valid  (pix_wr_valid),
        .line_done (line_done),
        .rd_idx    (buf_idx),
        .rd_pix    (buf_pix)
    );

    vga u_vga (
        .clk        (clk),
        .clk_en     (clk_en),
        .rst_n      (rst_n),
        .retro_look (retro_look),
        .buf_idx    (buf_idx),
        .buf_pix    (buf_pix),
        .hsync_n    (hsync_n),
        .vsync_n    (vsync_n),
        .blank      (blank),
        .pixel      (pixel)
    );

endmodule

//--- source/scanline_buffer.sv
`timescale 1ns/1ps

module scanline_buffer #(
    parameter int line_px = 256
) (
    input                          clk,
    input                          rst_n,
    input  nes_color_pkg::pix_wr_t wr,
    input                          wr_valid,
    input                          line_done,
    input  logic [7:0]             rd_idx,
    output nes_color_pkg::pal_idx_t rd_pix
);
    import nes_color_pkg::*;

    pal_idx_t mem [2][line_px];
    logic     wr_sel;    // bank being filled, the other one is displayed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_sel <= 1'b0;
        end else if (line_done) begin
            wr_sel <= ~wr_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_sel][wr.x] <= wr.idx;
        end
    end

    // columns past the line read as index 0
    always_comb begin
        if (rd_idx < line_px) begin
            rd_pix = mem[~wr_sel][rd_idx];
        end else begin
            rd_pix = '0;
        end
    end

    // renderer must stay inside the line
    a_wr_in_line: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid |-> (wr.x < line_px)
    ) else $error("scanline_buffer: write column %0d beyond line", wr.x);

    // a write next to a swap would land in an ambiguous bank
    a_wr_not_on_swap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_valid && line_done)
    ) else $error("scanline_buffer: write and line_done in the same cycle");

endmodule

//--- source/vga.sv
`timescale 1ns/1ps

module vga (
    input                           clk,
    input                           clk_en,
    input                           rst_n,
    input                           retro_look,
    output logic [7:0]              buf_idx,
    input  nes_color_pkg::pal_idx_t buf_pix,
    output logic                    hsync_n,
    output logic                    vsync_n,
    output logic                    blank,
    output nes_color_pkg::rgb_t     pixel
);
    import video_timing_pkg::*;
    import nes_color_pkg::*;

    logic [9:0] row, col;
    logic       row_end;

    vga_hs_state_t hs_state, hs_next;
    vga_vs_state_t vs_state, vs_next;

    rgb_t pal_color;
    logic visible;

    assign row_end = (col == h_total - 10'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (clk_en) begin
            if (row_end) begin
                col <= '0;
                // wrap at the end of the frame
                row <= (row == v_total - 10'd1) ? 10'd0 : row + 10'd1;
            end else begin
                col <= col + 10'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= hs_visible;
            vs_state <= vs_pre;
        end else if (clk_en) begin
            hs_state <= hs_next;
            vs_state <= vs_next;
        end
    end

    // horizontal phases, state moves on after the last column of each
    always_comb begin
        hs_next = hs_state;
        hsync_n = 1'b1;
        case (hs_state)
            hs_visible:     if (col == h_visible_end) hs_next = hs_front_porch;
            hs_front_porch: if (col == h_fp_end) hs_next = hs_pulse;
            hs_pulse: begin
                hsync_n = 1'b0;
                if (col == h_sync_end) hs_next = hs_back_porch;
            end
            hs_back_porch:  if (col == h_bp_end) hs_next = hs_idle;
            hs_idle:        if (row_end) hs_next = hs_visible;
            default:        hs_next = hs_visible;
        endcase
    end

    // vertical phases, only step at the end of a row
    always_comb begin
        vs_next = vs_state;
        vsync_n = 1'b1;
        case (vs_state)
            vs_pre:         if (row_end && row == v_pre_end) vs_next = vs_visible;
            vs_visible:     if (row_end && row == v_visible_end) vs_next = vs_front_porch;
            vs_front_porch: if (row_end && row == v_fp_end) vs_next = vs_pulse;
            vs_pulse: begin
                vsync_n = 1'b0;
                if (row_end && row == v_sync_end) vs_next = vs_back_porch;
            end
            vs_back_porch: begin
                if (row_end && row == v_total - 10'd1) vs_next = vs_pre;
            end
            default:        vs_next = vs_pre;
        endcase
    end

    assign visible = (hs_state == hs_visible) && (vs_state == vs_visible);
    assign blank   = ~visible;
    assign buf_idx = col[7:0];

    nes_palette u_palette (
        .idx   (buf_pix),
        .color (pal_color)
    );

    // scanline effect blacks out odd rows
    always_comb begin
        if (visible && !(retro_look && row[0])) begin
            pixel = pal_color;
        end else begin
            pixel = '0;
        end
    end

    // visible columns must line up with the visible state and never carry sync
    a_hsync_off_visible: assert property (
        @(posedge clk) disable iff (!rst_n)
        (col <= h_visible_end) |-> (hs_state == hs_visible && hsync_n)
    ) else $error("vga: hsync or state out of step at column %0d", col);

endmodule

//--- source/video_timing_pkg.sv
package video_timing_pkg;

    // horizontal, in pixel clocks
    localparam logic [9:0] h_total       = 10'd341;
    localparam logic [9:0] h_visible_end = 10'd255;
    localparam logic [9:0] h_fp_end      = 10'd262;
    localparam logic [9:0] h_sync_end    = 10'd303;
    localparam logic [9:0] h_bp_end      = 10'd323;

    // vertical, in rows
    localparam logic [9:0] v_total       = 10'd524;
    localparam logic [9:0] v_pre_end     = 10'd3;
    localparam logic [9:0] v_visible_end = 10'd483;
    localparam logic [9:0] v_fp_end      = 10'd493;
    localparam logic [9:0] v_sync_end    = 10'd495;

    typedef enum logic [2:0] {
        hs_visible,
        hs_front_porch,
        hs_pulse,
        hs_back_porch,
        hs_idle           // dead columns up to h_total - 1
    } vga_hs_state_t;

    typedef enum logic [2:0] {
        vs_pre,
        vs_visible,
        vs_front_porch,
        vs_pulse,
        vs_back_porch
    } vga_vs_state_t;

endpackage

//--- testbench/tb_ppu_video.sv
`timescale 1ns/1ps

module tb_ppu_video;
    import nes_color_pkg::*;
    import video_timing_pkg::*;

    localparam int     line_len      = 256;
    localparam int     n_entries     = 16;
    localparam int     entry_bits    = 4;     // enough to address every file entry
    localparam int     n_frames      = 2;
    localparam int     reset_cycles  = 10;
    localparam int     swap_row      = 200;   // second line goes in mid-frame
    localparam int     swap_col      = 300;   // inside horizontal blank
    localparam longint clk_period_ns = 100;
    // three frames plus reset and some slack
    localparam longint watchdog_ns =
        (reset_cycles + 3 * longint'(h_total) * longint'(v_total)) * clk_period_ns + 10_000;

    logic    clk;
    logic    clk_en;
    logic    rst_n;
    logic    retro_look;
    pix_wr_t pix_wr;
    logic    pix_wr_valid;
    logic    line_done;
    logic    hsync_n;
    logic    vsync_n;
    logic    blank;
    rgb_t    pixel;

    logic [7:0] raw [0:4*n_entries-1];   // four bytes per file line
    pal_idx_t   idx_tab   [n_entries];
    logic [7:0] red_tab   [n_entries];
    logic [7:0] green_tab [n_entries];
    logic [7:0] blue_tab  [n_entries];

    // file entry numbers that each bank should hold
    int          bank [2][line_len];
    bit          wr_bank;
    bit          retro;
    int          cur_row;
    int          cur_col;
    logic [31:0] lfsr_state;

    ppu_video #(
        .line_px (line_len)
    ) UUT (
        .clk          (clk),
        .clk_en       (clk_en),
        .rst_n        (rst_n),
        .retro_look   (retro_look),
        .pix_wr       (pix_wr),
        .pix_wr_valid (pix_wr_valid),
        .line_done    (line_done),
        .hsync_n      (hsync_n),
        .vsync_n      (vsync_n),
        .blank        (blank),
        .pixel        (pixel)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end
        return s;
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v          = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic fail_now(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic load_table();
        for (int i = 0; i < 4 * n_entries; i++) begin
            raw[i] = 8'hff;   // illegal index marks lines the file lacks
        end
        $readmemh("testbench/video_input.txt", raw);
        for (int i = 0; i < n_entries; i++) begin
            if (raw[4*i] > 8'h3f) begin
                $display("stimulus file testbench/video_input.txt is missing or too short");
                $display(">>> FAIL");
                $fatal(1, "no stimulus");
            end
            idx_tab[i]   = raw[4*i][5:0];
            red_tab[i]   = raw[4*i+1];
            green_tab[i] = raw[4*i+2];
            blue_tab[i]  = raw[4*i+3];
        end
    endtask

    task automatic check_sync(input logic exp_hs, input logic exp_vs, input logic exp_blank);
        if (hsync_n !== exp_hs) begin
            fail_now($sformatf("hsync_n %b, expected %b at row %0d col %0d",
                               hsync_n, exp_hs, cur_row, cur_col));
        end
        if (vsync_n !== exp_vs) begin
            fail_now($sformatf("vsync_n %b, expected %b at row %0d col %0d",
                               vsync_n, exp_vs, cur_row, cur_col));
        end
        if (blank !== exp_blank) begin
            fail_now($sformatf("blank %b, expected %b at row %0d col %0d",
                               blank, exp_blank, cur_row, cur_col));
        end
    endtask

    task automatic check_rgb(input rgb_t want);
        if (pixel !== want) begin
            fail_now($sformatf("pixel %h, expected %h at row %0d col %0d",
                               pixel, want, cur_row, cur_col));
        end
    endtask

    task automatic check_cell(input int r, input int c);
        bit   vis;
        int   e;
        rgb_t want;
        vis = (c <= h_visible_end) && (r > v_pre_end) && (r <= v_visible_end);
        check_sync(!((c > h_fp_end) && (c <= h_sync_end)),
                   !((r > v_fp_end) && (r <= v_sync_end)),
                   !vis);
        if (vis && !(retro && (r % 2 == 1))) begin
            e    = bank[~wr_bank][c];   // read side is the bank not being filled
            want = rgb_t'{red: red_tab[e], green: green_tab[e], blue: blue_tab[e]};
        end else begin
            want = '0;
        end
        check_rgb(want);
    endtask

    task automatic drive_cycle(input int f, input int r, input int c);
        int e;
        pix_wr_valid = 1'b0;
        line_done    = 1'b0;
        pix_wr       = '0;
        // first line in pre-row 0 and second one mid-frame
        if (f == 0 && (r == 0 || r == swap_row) && c < line_len) begin
            random_bits(entry_bits, e);
            pix_wr.x         = 8'(c);
            pix_wr.idx       = idx_tab[e];
            pix_wr_valid     = 1'b1;
            bank[wr_bank][c] = e;
        end
        if (f == 0 && ((r == 1 && c == 0) || (r == swap_row && c == swap_col))) begin
            line_done = 1'b1;
            wr_bank   = ~wr_bank;   // seen by the read port from the next cycle
        end
        if (f == 1 && r == 0 && c == 0) begin
            retro_look = 1'b1;   // second frame with the scanline effect
            retro      = 1'b1;
        end
    endtask

    initial begin
        clk          = 1'b0;
        clk_en       = 1'b1;
        rst_n        = 1'b0;
        retro_look   = 1'b0;
        pix_wr       = '0;
        pix_wr_valid = 1'b0;
        line_done    = 1'b0;
        wr_bank      = 1'b0;
        retro        = 1'b0;
        lfsr_state   = 32'hd64ac5f0;
        load_table();
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        // model starts at row 0 col 0 on release
        for (int f = 0; f < n_frames; f++) begin
            for (int r = 0; r < v_total; r++) begin
                for (int c = 0; c < h_total; c++) begin
                    cur_row = r;
                    cur_col = c;
                    check_cell(r, c);
                    drive_cycle(f, r, c);
                    @(negedge clk);
                end
            end
        end
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timed out after %0d ns before all frames were checked", $time);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- testbench/video_input.txt
// palette index, then its red, green and blue
// all values hex, one entry per line
00 54 54 54
01 00 1e 74
06 54 04 00
0a 00 40 00
0f 00 00 00
12 30 32 ec
16 98 22 20
1a 08 7c 00
1d 00 00 00
21 4c 9a ec
27 d4 88 20
2b 38 cc 6c
2d 3c 3c 3c
30 ec ee ec
36 ec b4 b0
3c a0 d6 e4
